//--- Bender.yml
package:
  name: seg_display

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - files:
      - segDisplayPkg.sv
      - wbDisplayBus.sv
      - digitRegisters.sv
      - blinkControl.sv
      - digitScanner.sv
      - segDisplayTop.sv

  # testbench, top module segDisplayTb
  - target: simulation
    files:
      - segDisplayTb.sv

//--- blinkControl.sv
// blink mask and period registers plus the free-running blink phase timer
`timescale 1ns/100ps

module blinkControl (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  logic                                   maskWr,
    input  logic                                   periodWr,
    input  logic [7:0]                             wrData,
    output logic [segDisplayPkg::NUM_DIGITS-1:0]   blinkMask,
    output logic [7:0]                             blinkPeriod,
    output logic                                   blinkOn
);
    import segDisplayPkg::*;

    logic [7:0] count;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            blinkMask <= '0;
        end else if (maskWr) begin
            blinkMask <= wrData[NUM_DIGITS-1:0];
        end
    end

    // phase flips after period+1 cycles, period zero means always on
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            blinkPeriod <= '0;
            count       <= '0;
            blinkOn     <= 1'b1;
        end else if (periodWr) begin
            // new period restarts the count
            blinkPeriod <= wrData;
            count       <= '0;
            if (wrData == '0) begin
                blinkOn <= 1'b1;
            end
        end else if (blinkPeriod == '0) begin
            count   <= '0;
            blinkOn <= 1'b1;
        end else if (count == blinkPeriod) begin
            count   <= '0;
            blinkOn <= !blinkOn;
        end else begin
            count <= count + 8'd1;
        end
    end

    // a disabled timer must never blank a digit
    steadyWhenIdle: assert property (
        @(posedge clk) disable iff (!nrst)
        (blinkPeriod == '0) |-> blinkOn
    );

endmodule

//--- digitRegisters.sv
// eight digit pattern registers, a write stores either a raw pattern or a glyph table entry
`timescale 1ns/100ps

module digitRegisters (
    input  logic                                    clk,
    input  logic                                    nrst,
    input  logic                                    digitWr,
    input  logic [segDisplayPkg::DIGIT_IDX_W-1:0]   digitIdx,
    input  logic                                    rawMode,
    input  segDisplayPkg::displayWord_u             wrWord,
    input  logic [segDisplayPkg::DIGIT_IDX_W-1:0]   rdIdx,
    output logic [segDisplayPkg::NUM_DIGITS*8-1:0]  digitSegs,
    output logic [7:0]                              rdSegs
);
    import segDisplayPkg::*;

    logic [7:0] pattern [NUM_DIGITS];
    logic [7:0] glyphSegs;
    logic [7:0] newSegs;

    // glyph table, common cathode, bit 0 = a
    always_comb begin
        glyphSegs = 8'h00;
        if (wrWord.glyph.index < 5'(GLYPH_COUNT)) begin
            case (wrWord.glyph.index)
                5'd0:  glyphSegs = 8'b0011_1111;
                5'd1:  glyphSegs = 8'b0000_0110;
                5'd2:  glyphSegs = 8'b0101_1011;
                5'd3:  glyphSegs = 8'b0100_1111;
                5'd4:  glyphSegs = 8'b0110_0110;
                5'd5:  glyphSegs = 8'b0110_1101;
                5'd6:  glyphSegs = 8'b0111_1101;
                5'd7:  glyphSegs = 8'b0000_0111;
                5'd8:  glyphSegs = 8'b0111_1111;
                5'd9:  glyphSegs = 8'b0110_1111;
                5'd10: glyphSegs = 8'b0111_0111;
                5'd11: glyphSegs = 8'b0111_1100;
                5'd12: glyphSegs = 8'b0011_1001;
                5'd13: glyphSegs = 8'b0101_1110;
                5'd14: glyphSegs = 8'b0111_1001;
                5'd15: glyphSegs = 8'b0111_0001;
                // letters
                5'd16: glyphSegs = 8'b0111_0110;
                5'd17: glyphSegs = 8'b0011_1110;
                5'd18: glyphSegs = 8'b0101_1100;
                5'd19: glyphSegs = 8'b0101_0000;
                // dash, middle bar only
                5'd20: glyphSegs = 8'b0100_0000;
                default: glyphSegs = 8'h00;
            endcase
        end
    end

    // raw mode keeps the byte as is, decimal point included
    assign newSegs = rawMode ? wrWord.raw : glyphSegs;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                pattern[i] <= '0;
            end
        end else if (digitWr) begin
            pattern[digitIdx] <= newSegs;
        end
    end

    // flat export for the scanner, digit 0 in the low byte
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            digitSegs[8*i +: 8] = pattern[i];
        end
    end

    assign rdSegs = pattern[rdIdx];

    // bus acks every write before the next one can start
    singleCycleWrite: assert property (
        @(posedge clk) disable iff (!nrst)
        digitWr |=> !digitWr
    );

endmodule

//--- digitScanner.sv
// time-multiplexes the eight digit patterns onto one segment bus and a one-hot select
`timescale 1ns/100ps

module digitScanner (
    input  logic                                    clk,
    input  logic                                    nrst,
    input  logic [segDisplayPkg::NUM_DIGITS*8-1:0]  digitSegs,
    input  logic [segDisplayPkg::NUM_DIGITS-1:0]    blinkMask,
    input  logic                                    blinkOn,
    output logic [7:0]                              segs,
    output logic [segDisplayPkg::NUM_DIGITS-1:0]    digitSel
);
    import segDisplayPkg::*;

    logic [$clog2(SCAN_DIV)-1:0] divCnt;
    logic [DIGIT_IDX_W-1:0]      digitCnt;
    logic [7:0]                  curSegs;
    logic                        blank;

    // divider and digit counter
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            divCnt   <= '0;
            digitCnt <= '0;
        end else if (divCnt == ($clog2(SCAN_DIV))'(SCAN_DIV - 1)) begin
            divCnt <= '0;
            if (digitCnt == DIGIT_IDX_W'(NUM_DIGITS - 1)) begin
                digitCnt <= '0;
            end else begin
                digitCnt <= digitCnt + 1'b1;
            end
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // pattern of the digit being scanned
    assign curSegs = digitSegs[8*digitCnt +: 8];

    // masked digits go dark in the off phase
    assign blank = blinkMask[digitCnt] && !blinkOn;

    // select and segments share one register stage so they stay paired
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            digitSel <= NUM_DIGITS'(1);
            segs     <= '0;
        end else begin
            digitSel <= NUM_DIGITS'(1) << digitCnt;
            segs     <= blank ? 8'h00 : curSegs;
        end
    end

    // exactly one digit driven at any time
    oneDigitSelected: assert property (
        @(posedge clk) disable iff (!nrst)
        $onehot(digitSel)
    );

endmodule

//--- flist.f
segDisplayPkg.sv
wbDisplayBus.sv
digitRegisters.sv
blinkControl.sv
digitScanner.sv
segDisplayTop.sv
segDisplayTb.sv

//--- segDisplayPkg.sv
// shared address map, scan and blink constants and write-word type for the display controller
package segDisplayPkg;

    // display geometry
    localparam int NUM_DIGITS  = 8;
    localparam int DIGIT_IDX_W = 3;

    // register window, all offsets relative to BASE_ADDR
    localparam logic [7:0] BASE_ADDR        = 8'h00;
    localparam logic [7:0] GLYPH_OFS        = 8'h00;
    localparam logic [7:0] RAW_OFS          = 8'h08;
    localparam logic [7:0] BLINK_MASK_OFS   = 8'h10;
    localparam logic [7:0] BLINK_PERIOD_OFS = 8'h11;

    // hex 0-F, then H, U, o, r and dash
    localparam int GLYPH_COUNT = 21;

    // clock cycles each digit stays selected
    localparam int SCAN_DIV = 4;

    // glyph-mode view of the write byte
    typedef struct packed {
        logic [2:0] unused;
        logic [4:0] index;
    } glyphFields_t;

    // one write byte, read either as a glyph code or as raw segments
    // raw bit 0 is segment a up to bit 6 for g, bit 7 is the decimal point
    typedef union packed {
        glyphFields_t glyph;
        logic [7:0]   raw;
    } displayWord_u;

endpackage

//--- segDisplayTb.sv
// testbench for the display controller, runs Wishbone cycles and checks readback and scan output
`timescale 1ns/100ps

module segDisplayTb;
    import segDisplayPkg::*;

    // test lengths, also used to size the timeout
    localparam int RAND_GLYPHS    = 16;
    localparam int NUM_UNMAPPED   = 4;
    localparam int RESET_TRANS    = 2 * NUM_DIGITS + 2;
    localparam int GLYPH_TRANS    = 2 * (NUM_DIGITS * GLYPH_COUNT + RAND_GLYPHS);
    localparam int RAW_TRANS      = 2 * NUM_DIGITS;
    localparam int UNMAPPED_TRANS = 2 * NUM_UNMAPPED + NUM_DIGITS + 2;
    localparam int SCAN_TRANS     = NUM_DIGITS + 1;
    localparam int BLINK_TRANS    = 7;
    localparam int TOTAL_TRANS    = RESET_TRANS + GLYPH_TRANS + RAW_TRANS + UNMAPPED_TRANS
                                    + SCAN_TRANS + BLINK_TRANS;
    localparam int SCAN_FRAMES    = 3;
    localparam int BLINK_FRAMES   = 4;
    localparam int STEADY_FRAMES  = 3;
    // one extra frame for the scan sync before the period write
    localparam int SCAN_WINDOWS   = SCAN_FRAMES + BLINK_FRAMES + STEADY_FRAMES + 1;
    localparam int FRAME_CYCLES   = NUM_DIGITS * SCAN_DIV;
    localparam int TIMEOUT_CYCLES = 2 * (TOTAL_TRANS * 3 + SCAN_WINDOWS * FRAME_CYCLES);

    // entry 0 in the low byte
    localparam logic [NUM_UNMAPPED-1:0][7:0] UNMAPPED = {8'hFF, 8'h80, 8'h3C, 8'h12};

    logic                  clk = 1'b0;
    logic                  nrst;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    logic [7:0]            wbAdr;
    logic [7:0]            wbDatW;
    logic [7:0]            wbDatR;
    logic                  wbAck;
    logic [7:0]            segs;
    logic [NUM_DIGITS-1:0] digitSel;

    // reference model
    logic [7:0]            expSegs [NUM_DIGITS];
    logic [NUM_DIGITS-1:0] expMask;
    logic [7:0]            expPeriod;

    // monitor control and coverage of the scan windows
    logic                  scanCheck = 1'b0;
    logic                  allowBlank = 1'b0;
    logic [NUM_DIGITS-1:0] seenDigit;
    logic [NUM_DIGITS-1:0] seenOn;
    logic [NUM_DIGITS-1:0] seenOff;
    int                    monIdx;

    int errors = 0;
    int checks = 0;
    int cycleCount = 0;

    segDisplayTop i_segDisplayTop (
        .clk, .nrst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
        .wbDatR, .wbAck, .segs, .digitSel
    );

    always #2 clk = ~clk;

    // common-cathode table, bit 0 = segment a
    function automatic logic [7:0] glyphRef(input int code);
        case (code)
            0:       return 8'h3F;
            1:       return 8'h06;
            2:       return 8'h5B;
            3:       return 8'h4F;
            4:       return 8'h66;
            5:       return 8'h6D;
            6:       return 8'h7D;
            7:       return 8'h07;
            8:       return 8'h7F;
            9:       return 8'h6F;
            10:      return 8'h77;
            11:      return 8'h7C;
            12:      return 8'h39;
            13:      return 8'h5E;
            14:      return 8'h79;
            15:      return 8'h71;
            16:      return 8'h76; // H
            17:      return 8'h3E; // U
            18:      return 8'h5C; // o
            19:      return 8'h50; // r
            20:      return 8'h40; // dash
            default: return 8'h00;
        endcase
    endfunction

    // index of the selected digit, -1 unless one-hot
    function automatic int selIndex(input logic [NUM_DIGITS-1:0] sel);
        int idx;
        idx = -1;
        if ($onehot(sel)) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (sel[i]) begin
                    idx = i;
                end
            end
        end
        return idx;
    endfunction

    task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s, got %0h, expected %0h", $realtime, what, got, exp);
        end
    endtask

    // one classic cycle, request held until ack, data sampled mid-cycle
    task automatic busCycle(input logic we, input logic [7:0] adr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
        @(posedge clk);
        #0.5;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = wdata;
        do begin
            @(negedge clk);
        end while (!wbAck);
        rdata = wbDatR;
        @(posedge clk);
        #0.5;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input logic [7:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        busCycle(1'b1, adr, data, unused);
    endtask

    task automatic wbRead(input logic [7:0] adr, output logic [7:0] data);
        busCycle(1'b0, adr, 8'h00, data);
    endtask

    task automatic readCheck(input logic [7:0] adr, input logic [7:0] exp, input string what);
        logic [7:0] data;
        wbRead(adr, data);
        checkVal(data, exp, $sformatf("%s at 0x%02h", what, adr));
    endtask

    // scan monitor, masked digits may go dark only while blinking is allowed
    always @(negedge clk) begin
        if (scanCheck) begin
            monIdx = selIndex(digitSel);
            if (monIdx < 0) begin
                errors++;
                $display("** Error at %0t: digitSel is not one-hot, got %b", $realtime, digitSel);
            end else begin
                seenDigit[monIdx] = 1'b1;
                if (allowBlank && expMask[monIdx] && segs == 8'h00) begin
                    seenOff[monIdx] = 1'b1;
                end else begin
                    checkVal(segs, expSegs[monIdx], $sformatf("segs of digit %0d", monIdx));
                    if (segs == expSegs[monIdx]) begin
                        seenOn[monIdx] = 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, a bus cycle or wait never ended", cycleCount);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        logic [7:0]            data;
        logic [7:0]            code;
        int                    d;
        logic [NUM_DIGITS-1:0] prevSel;

        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'hf78e8a7a));
        nrst   = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            expSegs[i] = '0;
        end
        expMask   = '0;
        expPeriod = '0;
        repeat (2) @(posedge clk);
        #0.5;
        nrst = 1'b1;

        // reset state, no ack without a full request
        @(negedge clk);
        checkVal(segs, 8'h00, "segs after reset");
        checkVal($onehot(digitSel), 1, "digitSel one-hot after reset");
        checkVal(wbAck, 1'b0, "wbAck idle");
        @(posedge clk);
        #0.5;
        wbCyc = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checkVal(wbAck, 1'b0, "wbAck with wbCyc alone");
        end
        @(posedge clk);
        #0.5;
        wbCyc = 1'b0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            readCheck(BASE_ADDR + GLYPH_OFS + 8'(i), 8'h00, "reset glyph readback");
            readCheck(BASE_ADDR + RAW_OFS + 8'(i), 8'h00, "reset raw readback");
        end
        readCheck(BASE_ADDR + BLINK_MASK_OFS, 8'h00, "reset mask");
        readCheck(BASE_ADDR + BLINK_PERIOD_OFS, 8'h00, "reset period");

        // every defined glyph on every digit, then random codes with junk high bits
        for (int i = 0; i < NUM_DIGITS; i++) begin
            for (int c = 0; c < GLYPH_COUNT; c++) begin
                wbWrite(BASE_ADDR + GLYPH_OFS + 8'(i), 8'(c));
                expSegs[i] = glyphRef(c);
                readCheck(BASE_ADDR + GLYPH_OFS + 8'(i), expSegs[i], "glyph readback");
            end
        end
        repeat (RAND_GLYPHS) begin
            d    = $urandom % NUM_DIGITS;
            code = 8'($urandom % 32);
            data = {3'($urandom), code[4:0]};
            wbWrite(BASE_ADDR + GLYPH_OFS + 8'(d), data);
            expSegs[d] = glyphRef(code);
            readCheck(BASE_ADDR + RAW_OFS + 8'(d), expSegs[d], "random glyph readback");
        end

        // raw patterns kept bit for bit
        for (int i = 0; i < NUM_DIGITS; i++) begin
            data = 8'($urandom);
            wbWrite(BASE_ADDR + RAW_OFS + 8'(i), data);
            expSegs[i] = data;
            readCheck(BASE_ADDR + RAW_OFS + 8'(i), expSegs[i], "raw readback");
        end

        // unmapped writes are dropped and read as zero
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            wbWrite(UNMAPPED[i], 8'($urandom));
            readCheck(UNMAPPED[i], 8'h00, "unmapped readback");
        end
        for (int i = 0; i < NUM_DIGITS; i++) begin
            readCheck(BASE_ADDR + GLYPH_OFS + 8'(i), expSegs[i], "digit after unmapped writes");
        end
        readCheck(BASE_ADDR + BLINK_MASK_OFS, expMask, "mask after unmapped writes");
        readCheck(BASE_ADDR + BLINK_PERIOD_OFS, expPeriod, "period after unmapped writes");

        // nonzero patterns so a blanked digit is always visible
        for (int i = 0; i < NUM_DIGITS; i++) begin
            expSegs[i] = 8'($urandom) | 8'h01;
            wbWrite(BASE_ADDR + RAW_OFS + 8'(i), expSegs[i]);
        end
        wbWrite(BASE_ADDR + BLINK_MASK_OFS, 8'h00);
        seenDigit = '0;
        scanCheck = 1'b1;
        repeat (SCAN_FRAMES * FRAME_CYCLES) @(posedge clk);
        scanCheck = 1'b0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (!seenDigit[i]) begin
                errors++;
                $display("digit %0d never appeared during the scan window", i);
            end
        end

        // blink with a mixed mask
        expMask = (NUM_DIGITS'($urandom) & 8'h7F) | 8'h01;
        wbWrite(BASE_ADDR + BLINK_MASK_OFS, expMask);
        readCheck(BASE_ADDR + BLINK_MASK_OFS, expMask, "mask readback");
        // land the period write off the digit boundary so each window sees both phases
        @(negedge clk);
        prevSel = digitSel;
        do begin
            @(negedge clk);
        end while (digitSel == prevSel);
        expPeriod = 8'd3;
        wbWrite(BASE_ADDR + BLINK_PERIOD_OFS, expPeriod);
        seenOn     = '0;
        seenOff    = '0;
        allowBlank = 1'b1;
        scanCheck  = 1'b1;
        repeat (BLINK_FRAMES * FRAME_CYCLES) @(posedge clk);
        scanCheck  = 1'b0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (expMask[i] && !(seenOn[i] && seenOff[i])) begin
                errors++;
                $display("masked digit %0d did not show both blink phases", i);
            end
        end
        readCheck(BASE_ADDR + BLINK_PERIOD_OFS, expPeriod, "period readback");

        // period zero stops blinking for good
        expPeriod = 8'd0;
        wbWrite(BASE_ADDR + BLINK_PERIOD_OFS, expPeriod);
        allowBlank = 1'b0;
        scanCheck  = 1'b1;
        repeat (STEADY_FRAMES * FRAME_CYCLES) @(posedge clk);
        scanCheck  = 1'b0;
        readCheck(BASE_ADDR + BLINK_PERIOD_OFS, expPeriod, "period readback after stop");
        readCheck(BASE_ADDR + BLINK_MASK_OFS, expMask, "mask readback after stop");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- segDisplayTop.sv
// top level of the display controller, connects the bus slave, registers, blink timer and scanner
`timescale 1ns/100ps

module segDisplayTop (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 wbCyc,
    input  logic                                 wbStb,
    input  logic                                 wbWe,
    input  logic [7:0]                           wbAdr,
    input  logic [7:0]                           wbDatW,
    output logic [7:0]                           wbDatR,
    output logic                                 wbAck,
    output logic [7:0]                           segs,
    output logic [segDisplayPkg::NUM_DIGITS-1:0] digitSel
);
    import segDisplayPkg::*;

    // bus to digit registers
    logic                    digitWr;
    logic [DIGIT_IDX_W-1:0]  digitIdx;
    logic                    rawMode;
    displayWord_u            wrWord;
    logic [DIGIT_IDX_W-1:0]  rdIdx;
    logic [7:0]              rdSegs;

    // bus to blink control
    logic                    maskWr;
    logic                    periodWr;
    logic [7:0]              wrData;
    logic [NUM_DIGITS-1:0]   blinkMask;
    logic [7:0]              blinkPeriod;
    logic                    blinkOn;

    logic [NUM_DIGITS*8-1:0] digitSegs;

    wbDisplayBus i_wbDisplayBus (
        .clk, .nrst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
        .rdSegs, .blinkMask, .blinkPeriod,
        .wbDatR, .wbAck, .digitWr, .digitIdx, .rawMode, .wrWord,
        .maskWr, .periodWr, .wrData, .rdIdx
    );

    digitRegisters i_digitRegisters (
        .clk, .nrst, .digitWr, .digitIdx, .rawMode, .wrWord, .rdIdx,
        .digitSegs, .rdSegs
    );

    blinkControl i_blinkControl (
        .clk, .nrst, .maskWr, .periodWr, .wrData,
        .blinkMask, .blinkPeriod, .blinkOn
    );

    digitScanner i_digitScanner (
        .clk, .nrst, .digitSegs, .blinkMask, .blinkOn,
        .segs, .digitSel
    );

endmodule

//--- wbDisplayBus.sv
// Wishbone classic slave for the display controller, turns bus cycles into register strobes
`timescale 1ns/100ps

module wbDisplayBus (
    input  logic                                  clk,
    input  logic                                  nrst,
    input  logic                                  wbCyc,
    input  logic                                  wbStb,
    input  logic                                  wbWe,
    input  logic [7:0]                            wbAdr,
    input  logic [7:0]                            wbDatW,
    input  logic [7:0]                            rdSegs,
    input  logic [segDisplayPkg::NUM_DIGITS-1:0]  blinkMask,
    input  logic [7:0]                            blinkPeriod,
    output logic [7:0]                            wbDatR,
    output logic                                  wbAck,
    output logic                                  digitWr,
    output logic [segDisplayPkg::DIGIT_IDX_W-1:0] digitIdx,
    output logic                                  rawMode,
    output segDisplayPkg::displayWord_u           wrWord,
    output logic                                  maskWr,
    output logic                                  periodWr,
    output logic [7:0]                            wrData,
    output logic [segDisplayPkg::DIGIT_IDX_W-1:0] rdIdx
);
    import segDisplayPkg::*;

    logic       req;
    logic       wrReq;
    logic [7:0] ofs;
    logic [7:0] glyphRel;
    logic [7:0] rawRel;
    logic       glyphHit;
    logic       rawHit;
    logic       maskHit;
    logic       periodHit;
    logic [7:0] rdData;
    logic [DIGIT_IDX_W-1:0] selIdx;

    // new request only while ack is low, so every transfer is acked once
    assign req   = wbCyc && wbStb && !wbAck;
    assign wrReq = req && wbWe;

    // address decode
    assign ofs       = wbAdr - BASE_ADDR;
    assign glyphRel  = ofs - GLYPH_OFS;
    assign rawRel    = ofs - RAW_OFS;
    assign glyphHit  = glyphRel < 8'(NUM_DIGITS);
    assign rawHit    = rawRel < 8'(NUM_DIGITS);
    assign maskHit   = ofs == BLINK_MASK_OFS;
    assign periodHit = ofs == BLINK_PERIOD_OFS;

    assign selIdx = rawHit ? rawRel[DIGIT_IDX_W-1:0] : glyphRel[DIGIT_IDX_W-1:0];

    // strobes fire in the cycle before ack, registers load on the ack edge
    assign digitWr  = wrReq && (glyphHit || rawHit);
    assign maskWr   = wrReq && maskHit;
    assign periodWr = wrReq && periodHit;
    assign digitIdx = selIdx;
    assign rdIdx    = selIdx;
    assign rawMode  = rawHit;
    assign wrWord   = displayWord_u'(wbDatW);
    assign wrData   = wbDatW;

    // read mux, unmapped addresses give zero
    always_comb begin
        rdData = '0;
        if (glyphHit || rawHit) begin
            rdData = rdSegs;
        end else if (maskHit) begin
            rdData = blinkMask;
        end else if (periodHit) begin
            rdData = blinkPeriod;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wbAck  <= 1'b0;
            wbDatR <= '0;
        end else begin
            wbAck  <= req;
            wbDatR <= (req && !wbWe) ? rdData : '0;
        end
    end

    // the master holds its request until the ack it gets
    ackInsideCycle: assert property (
        @(posedge clk) disable iff (!nrst)
        wbAck |-> (wbCyc && wbStb)
    );

endmodule
